// File: verilog/mipsPkg.sv
package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;

	// primary opcode field, ir[31:26]
	typedef enum logic [5:0] {
		OpFunct = 6'h00,	// R-type, decoded by funct
		OpJ     = 6'h02,
		OpBeq   = 6'h04,
		OpBne   = 6'h05,
		OpLw    = 6'h23,
		OpSw    = 6'h2b
	} opcodeT;

	// funct field of R-type words, ir[5:0]
	typedef enum logic [5:0] {
		FnNop   = 6'h00,
		FnBreak = 6'h0d,	// halts the core
		FnAdd   = 6'h20,
		FnSub   = 6'h22,
		FnAnd   = 6'h24,
		FnXor   = 6'h26
	} functT;

	typedef enum logic [1:0] {
		AluAdd = 2'b00,	// also the all-zero default
		AluSub = 2'b01,
		AluAnd = 2'b10,
		AluXor = 2'b11
	} aluOpT;

	typedef enum logic [3:0] {
		Fetch, FetchRelease, Decode,
		ExecR, WriteR,
		MemAddr, MemAccess, MemRelease, WriteLoad,
		Branch, Jump, Halt
	} stateT;

	// control word, one per FSM state
	typedef struct packed {
		logic irWrite;
		logic pcWrite;
		logic branchEq;	// pc write when zero
		logic branchNe;	// pc write when not zero
		logic aLoad;
		logic bLoad;
		logic aluOutLoad;
		logic mdrLoad;
		logic regWrite;
		logic memToReg;	// write back mdr instead of aluOut
		logic regDst;	// rd instead of rt
		logic iOrD;	// data address instead of pc
		logic aluSrcA;	// A register instead of pc
		logic [1:0] aluSrcB;	// B, 4, offset, offset << 2
		logic [1:0] pcSource;	// alu result, aluOut, jump target
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		logic [DataWidth-1:0] addr;
		logic [DataWidth-1:0] wData;
		logic we;
	} memReqT;

endpackage

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
	input logic [mipsPkg::DataWidth-1:0] a,
	input logic [mipsPkg::DataWidth-1:0] b,
	input mipsPkg::aluOpT op,
	output logic [mipsPkg::DataWidth-1:0] y,
	output logic zero
);

	always_comb
	begin
		case (op)
			mipsPkg::AluAdd:
				y = a + b;
			mipsPkg::AluSub:
				y = a - b;
			mipsPkg::AluAnd:
				y = a & b;
			mipsPkg::AluXor:
				y = a ^ b;
			default:
				y = a + b;
		endcase
	end

	// branch compare flag
	assign zero = (y == '0);

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic Clk,
	input logic rstN,
	input logic [mipsPkg::RegAddrWidth-1:0] rAddr1,
	input logic [mipsPkg::RegAddrWidth-1:0] rAddr2,
	input logic [mipsPkg::RegAddrWidth-1:0] wAddr,
	input logic [mipsPkg::DataWidth-1:0] wData,
	input logic we,
	output logic [mipsPkg::DataWidth-1:0] rData1,
	output logic [mipsPkg::DataWidth-1:0] rData2
);

	logic [mipsPkg::DataWidth-1:0] regs [2**mipsPkg::RegAddrWidth];

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 2**mipsPkg::RegAddrWidth; i++)
				regs[i] <= '0;
		end
		else if (we && (wAddr != '0))	// $zero is never written
		begin
			regs[wAddr] <= wData;
		end
	end

	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

endmodule

// File: verilog/memPort.sv
`timescale 1ns/1ps

module memPort (
	input logic Clk,
	input logic rstN,
	input logic memStart,
	input logic memAck,
	output logic memReqValid,
	output logic memDone,
	output logic memIdle
);

	typedef enum logic [1:0] {
		PhIdle,
		PhReq,
		PhRelease
	} phaseT;

	phaseT phase;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			phase <= PhIdle;
		else
		begin
			case (phase)
				PhIdle:
					if (memStart)
						phase <= PhReq;
				PhReq:
					if (memAck)	// data captured this cycle
						phase <= PhRelease;
				PhRelease:
					if (!memAck)
						phase <= PhIdle;
				default:
					phase <= PhIdle;
			endcase
		end
	end

	assign memReqValid = (phase == PhReq);
	assign memDone = (phase == PhReq) && memAck;	// first ack cycle only
	assign memIdle = (phase == PhIdle);

	assert property (@(posedge Clk) disable iff (!rstN)
		$rose(memReqValid) |-> !memAck);

	assert property (@(posedge Clk) disable iff (!rstN)
		(memReqValid && !memAck) |=> memReqValid);

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps

module datapath #(
	parameter logic [mipsPkg::DataWidth-1:0] ResetPc = '0
) (
	input logic Clk,
	input logic rstN,
	input mipsPkg::ctrlT ctrl,
	input logic [mipsPkg::DataWidth-1:0] memRData,
	input logic memDone,
	output mipsPkg::opcodeT opcode,
	output mipsPkg::functT funct,
	output logic aluZero,
	output mipsPkg::memReqT memReq
);

	logic [mipsPkg::DataWidth-1:0] pc;
	logic [mipsPkg::DataWidth-1:0] ir;
	logic [mipsPkg::DataWidth-1:0] mdr;
	logic [mipsPkg::DataWidth-1:0] aReg;
	logic [mipsPkg::DataWidth-1:0] bReg;
	logic [mipsPkg::DataWidth-1:0] aluOut;
	logic [mipsPkg::DataWidth-1:0] rData1;
	logic [mipsPkg::DataWidth-1:0] rData2;
	logic [mipsPkg::DataWidth-1:0] srcA;
	logic [mipsPkg::DataWidth-1:0] srcB;
	logic [mipsPkg::DataWidth-1:0] aluY;
	logic [mipsPkg::DataWidth-1:0] signExt;
	logic [mipsPkg::DataWidth-1:0] pcNext;
	logic [mipsPkg::DataWidth-1:0] regWData;
	logic [mipsPkg::RegAddrWidth-1:0] regWAddr;
	logic pcEn;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			pc <= ResetPc;
		else if (pcEn)
			pc <= pcNext;
	end

	always_ff @(posedge Clk)
	begin
		if (ctrl.irWrite && memDone)
			ir <= memRData;
		if (ctrl.mdrLoad && memDone)
			mdr <= memRData;
		if (ctrl.aLoad)
			aReg <= rData1;
		if (ctrl.bLoad)
			bReg <= rData2;
		if (ctrl.aluOutLoad)
			aluOut <= aluY;
	end

	assign opcode = mipsPkg::opcodeT'(ir[31:26]);
	assign funct = mipsPkg::functT'(ir[5:0]);

	assign regWAddr = ctrl.regDst ? ir[15:11] : ir[20:16];	// rd or rt
	assign regWData = ctrl.memToReg ? mdr : aluOut;

	regFile regFile_i (
		.Clk(Clk),
		.rstN(rstN),
		.rAddr1(ir[25:21]),
		.rAddr2(ir[20:16]),
		.wAddr(regWAddr),
		.wData(regWData),
		.we(ctrl.regWrite),
		.rData1(rData1),
		.rData2(rData2)
	);

	assign signExt = {{16{ir[15]}}, ir[15:0]};
	assign srcA = ctrl.aluSrcA ? aReg : pc;

	always_comb
	begin
		case (ctrl.aluSrcB)
			2'b00:
				srcB = bReg;
			2'b01:
				srcB = mipsPkg::DataWidth'(4);
			2'b10:
				srcB = signExt;
			default:
				srcB = signExt << 2;	// word offset
		endcase
	end

	alu alu_i (
		.a(srcA),
		.b(srcB),
		.op(ctrl.aluOp),
		.y(aluY),
		.zero(aluZero)
	);

	always_comb
	begin
		case (ctrl.pcSource)
			2'b01:
				pcNext = aluOut;
			2'b10:
				pcNext = {pc[31:28], ir[25:0], 2'b00};	// j target in current region
			default:
				pcNext = aluY;
		endcase
	end

	assign pcEn = ctrl.pcWrite | (ctrl.branchEq & aluZero) | (ctrl.branchNe & ~aluZero);

	assign memReq.addr = ctrl.iOrD ? aluOut : pc;
	assign memReq.wData = bReg;
	assign memReq.we = ctrl.iOrD && (opcode == mipsPkg::OpSw);	// data phase of sw

	assert property (@(posedge Clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

// File: verilog/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
	input logic Clk,
	input logic rstN,
	input mipsPkg::opcodeT opcode,
	input mipsPkg::functT funct,
	input logic aluZero,
	input logic memDone,
	input logic memIdle,
	output mipsPkg::ctrlT ctrl,
	output logic memStart,
	output logic halted
);

	mipsPkg::stateT state;
	mipsPkg::stateT nextState;
	mipsPkg::aluOpT rOp;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			state <= mipsPkg::Fetch;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (funct)
			mipsPkg::FnSub:
				rOp = mipsPkg::AluSub;
			mipsPkg::FnAnd:
				rOp = mipsPkg::AluAnd;
			mipsPkg::FnXor:
				rOp = mipsPkg::AluXor;
			default:
				rOp = mipsPkg::AluAdd;
		endcase
	end

	always_comb
	begin
		nextState = state;
		case (state)
			mipsPkg::Fetch:
				if (memDone)
					nextState = mipsPkg::FetchRelease;
			mipsPkg::FetchRelease:
				if (memIdle)	// ack has dropped
					nextState = mipsPkg::Decode;
			mipsPkg::Decode:
			begin
				case (opcode)
					mipsPkg::OpFunct:
					begin
						case (funct)
							mipsPkg::FnAdd, mipsPkg::FnSub, mipsPkg::FnAnd, mipsPkg::FnXor:
								nextState = mipsPkg::ExecR;
							mipsPkg::FnBreak:
								nextState = mipsPkg::Halt;
							default:
								nextState = mipsPkg::Fetch;	// nop and unknown functs
						endcase
					end
					mipsPkg::OpBeq, mipsPkg::OpBne:
						nextState = mipsPkg::Branch;
					mipsPkg::OpLw, mipsPkg::OpSw:
						nextState = mipsPkg::MemAddr;
					mipsPkg::OpJ:
						nextState = mipsPkg::Jump;
					default:
						nextState = mipsPkg::Fetch;
				endcase
			end
			mipsPkg::ExecR:
				nextState = mipsPkg::WriteR;
			mipsPkg::MemAddr:
				nextState = mipsPkg::MemAccess;
			mipsPkg::MemAccess:
				if (memDone)
					nextState = mipsPkg::MemRelease;
			mipsPkg::MemRelease:
				if (memIdle)
					nextState = (opcode == mipsPkg::OpLw) ? mipsPkg::WriteLoad : mipsPkg::Fetch;
			mipsPkg::Halt:
				nextState = mipsPkg::Halt;
			default:
				nextState = mipsPkg::Fetch;	// WriteR, WriteLoad, Branch, Jump
		endcase
	end

	always_comb
	begin
		ctrl = '0;
		memStart = 1'b0;
		case (state)
			mipsPkg::Fetch:
			begin
				memStart = 1'b1;
				ctrl.irWrite = memDone;	// ir takes the fetched word
				ctrl.pcWrite = memDone;	// pc + 4 with the instruction
				ctrl.aluSrcB = 2'b01;
			end
			mipsPkg::Decode:
			begin
				ctrl.aLoad = 1'b1;
				ctrl.bLoad = 1'b1;
				ctrl.aluOutLoad = 1'b1;	// branch target
				ctrl.aluSrcB = 2'b11;
			end
			mipsPkg::ExecR:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp = rOp;
				ctrl.aluOutLoad = 1'b1;
			end
			mipsPkg::WriteR:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
			end
			mipsPkg::MemAddr:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
				ctrl.aluOutLoad = 1'b1;
			end
			mipsPkg::MemAccess:
			begin
				memStart = 1'b1;
				ctrl.iOrD = 1'b1;
				ctrl.mdrLoad = 1'b1;
			end
			mipsPkg::MemRelease:
				ctrl.iOrD = 1'b1;
			mipsPkg::WriteLoad:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			mipsPkg::Branch:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOp = mipsPkg::AluSub;	// A - B for the zero flag
				ctrl.pcSource = 2'b01;
				ctrl.branchEq = (opcode == mipsPkg::OpBeq);
				ctrl.branchNe = (opcode == mipsPkg::OpBne);
			end
			mipsPkg::Jump:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = 2'b10;
			end
			default:
				ctrl = '0;
		endcase
	end

	assign halted = (state == mipsPkg::Halt);

	// no memory traffic once decoding or halted
	assert property (@(posedge Clk) disable iff (!rstN)
		(state inside {mipsPkg::Decode, mipsPkg::Halt}) |-> !memStart);

	// operands loaded in Decode give a defined branch decision
	assert property (@(posedge Clk) disable iff (!rstN)
		(state == mipsPkg::Branch) |-> !$isunknown(aluZero));

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter logic [mipsPkg::DataWidth-1:0] ResetPc = '0
) (
	input logic Clk,
	input logic rstN,
	output mipsPkg::memReqT memReq,
	output logic memReqValid,
	input logic memAck,
	input logic [mipsPkg::DataWidth-1:0] memRData,
	output logic halted
);

	mipsPkg::ctrlT ctrl;
	mipsPkg::opcodeT opcode;
	mipsPkg::functT funct;
	logic aluZero;
	logic memStart;
	logic memDone;
	logic memIdle;

	controlFsm controlFsm_i (
		.Clk(Clk),
		.rstN(rstN),
		.opcode(opcode),
		.funct(funct),
		.aluZero(aluZero),
		.memDone(memDone),
		.memIdle(memIdle),
		.ctrl(ctrl),
		.memStart(memStart),
		.halted(halted)
	);

	datapath #(
		.ResetPc(ResetPc)
	) datapath_i (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.memRData(memRData),
		.memDone(memDone),
		.opcode(opcode),
		.funct(funct),
		.aluZero(aluZero),
		.memReq(memReq)
	);

	memPort memPort_i (
		.Clk(Clk),
		.rstN(rstN),
		.memStart(memStart),
		.memAck(memAck),
		.memReqValid(memReqValid),
		.memDone(memDone),
		.memIdle(memIdle)
	);

endmodule

// File: dv/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int MemWords = 256;
	localparam int NumStores = 10;
	localparam int ExecutedInstr = 24;	// fetches on the taken path, break included
	localparam int TimeoutCycles = 400 * ExecutedInstr;
	localparam int DrainCycles = 20;	// quiet time checked after halt
	localparam logic [31:0] DataBase = 32'h0000_0200;
	localparam logic [31:0] Seed = 32'ha1271aad;

	logic Clk = 1'b0;
	logic rstN = 1'b0;
	logic memAck = 1'b0;
	logic [31:0] memRData = 32'h0;
	mipsPkg::memReqT memReq;
	logic memReqValid;
	logic halted;

	logic [31:0] mem [MemWords];
	logic [31:0] expAddr [NumStores];
	logic [31:0] expData [NumStores];
	int errorCount = 0;
	int storeIdx = 0;
	int fetchCount = 0;
	int cycleCount = 0;
	int delayLeft = 0;
	int releaseLeft = 0;
	bit pending = 1'b0;	// request seen, ack delay running

	always #5 Clk = ~Clk;

	mipsCore #(
		.ResetPc(32'h0)
	) mipsCore_i (
		.Clk(Clk),
		.rstN(rstN),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.memAck(memAck),
		.memRData(memRData),
		.halted(halted)
	);

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(input logic [31:0] target);
		return {mipsPkg::OpJ, target[27:2]};	// word index of the byte target
	endfunction

	task automatic putWord(input logic [31:0] addr, input logic [31:0] word);
		mem[addr[9:2]] = word;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			errorCount++;
			$display("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
		if (storeIdx >= NumStores)
		begin
			errorCount++;
			$display("%0t ns: store to 0x%08h after the last expected store", $time, addr);
		end
		else
		begin
			checkValue("memReq.addr", addr, expAddr[storeIdx]);
			checkValue("memReq.wData", data, expData[storeIdx]);
			storeIdx++;
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < MemWords; i++)
			mem[i] = 32'hBAD0_0000 | 32'(i);	// unknown opcode in every spare word
		putWord(32'h00, iType(mipsPkg::OpLw, 5'd0, 5'd1, 16'h0200));
		putWord(32'h04, iType(mipsPkg::OpLw, 5'd0, 5'd2, 16'h0204));
		putWord(32'h08, rType(5'd1, 5'd2, 5'd3, mipsPkg::FnAdd));
		putWord(32'h0C, rType(5'd1, 5'd2, 5'd4, mipsPkg::FnSub));
		putWord(32'h10, rType(5'd1, 5'd2, 5'd5, mipsPkg::FnAnd));
		putWord(32'h14, rType(5'd1, 5'd2, 5'd6, mipsPkg::FnXor));
		putWord(32'h18, rType(5'd1, 5'd2, 5'd4, mipsPkg::FnNop));	// would clobber r4 if run
		putWord(32'h1C, iType(mipsPkg::OpSw, 5'd0, 5'd3, 16'h0300));
		putWord(32'h20, iType(mipsPkg::OpSw, 5'd0, 5'd4, 16'h0304));
		putWord(32'h24, iType(mipsPkg::OpSw, 5'd0, 5'd5, 16'h0308));
		putWord(32'h28, iType(mipsPkg::OpSw, 5'd0, 5'd6, 16'h030C));
		putWord(32'h2C, iType(mipsPkg::OpLw, 5'd0, 5'd7, 16'h0208));
		putWord(32'h30, iType(mipsPkg::OpSw, 5'd0, 5'd7, 16'h0310));	// copy of loaded word
		putWord(32'h34, iType(mipsPkg::OpBeq, 5'd1, 5'd1, 16'h0001));	// taken
		putWord(32'h38, iType(mipsPkg::OpSw, 5'd0, 5'd1, 16'h03F0));	// marker
		putWord(32'h3C, iType(mipsPkg::OpSw, 5'd0, 5'd2, 16'h0314));
		putWord(32'h40, iType(mipsPkg::OpBeq, 5'd1, 5'd2, 16'h0001));	// not taken
		putWord(32'h44, iType(mipsPkg::OpSw, 5'd0, 5'd3, 16'h0318));
		putWord(32'h48, iType(mipsPkg::OpBne, 5'd1, 5'd2, 16'h0001));	// taken
		putWord(32'h4C, iType(mipsPkg::OpSw, 5'd0, 5'd1, 16'h03F4));	// marker
		putWord(32'h50, iType(mipsPkg::OpSw, 5'd0, 5'd4, 16'h031C));
		putWord(32'h54, iType(mipsPkg::OpBne, 5'd1, 5'd1, 16'h0001));	// not taken
		putWord(32'h58, iType(mipsPkg::OpSw, 5'd0, 5'd5, 16'h0320));
		putWord(32'h5C, jType(32'h64));
		putWord(32'h60, iType(mipsPkg::OpSw, 5'd0, 5'd1, 16'h03F8));	// marker
		putWord(32'h64, iType(mipsPkg::OpSw, 5'd0, 5'd6, 16'h0324));
		putWord(32'h68, rType(5'd0, 5'd0, 5'd0, mipsPkg::FnBreak));
		putWord(32'h6C, iType(mipsPkg::OpSw, 5'd0, 5'd1, 16'h03FC));	// never reached
		putWord(DataBase, 32'h1234_5678);
		putWord(DataBase + 32'h4, 32'h0F0F_00FF);
		putWord(DataBase + 32'h8, 32'hCAFE_F00D);
	endtask

	// results worked out by hand from the operand words above
	task automatic loadExpected();
		expAddr[0] = 32'h300;
		expData[0] = 32'h2143_5777;	// add
		expAddr[1] = 32'h304;
		expData[1] = 32'h0325_5579;	// sub
		expAddr[2] = 32'h308;
		expData[2] = 32'h0204_0078;	// and
		expAddr[3] = 32'h30C;
		expData[3] = 32'h1D3B_5687;	// xor
		expAddr[4] = 32'h310;
		expData[4] = 32'hCAFE_F00D;
		expAddr[5] = 32'h314;
		expData[5] = 32'h0F0F_00FF;
		expAddr[6] = 32'h318;
		expData[6] = 32'h2143_5777;
		expAddr[7] = 32'h31C;
		expData[7] = 32'h0325_5579;
		expAddr[8] = 32'h320;
		expData[8] = 32'h0204_0078;
		expAddr[9] = 32'h324;
		expData[9] = 32'h1D3B_5687;
	endtask

	task automatic serveRequest();
		logic [7:0] idx;
		idx = memReq.addr[9:2];
		if ((memReq.addr[31:10] != '0) || (memReq.addr[1:0] != 2'b00))
		begin
			errorCount++;
			$display("%0t ns: access to 0x%08h outside the word memory", $time, memReq.addr);
		end
		if (memReq.we)
		begin
			checkStore(memReq.addr, memReq.wData);
			mem[idx] = memReq.wData;
		end
		else if (memReq.addr < DataBase)
			fetchCount++;
		memRData = mem[idx];
		memAck = 1'b1;
		releaseLeft = $urandom % 4;	// ack hold after req drops
		pending = 1'b0;
	endtask

	// memory side of the four-phase handshake
	always @(posedge Clk)
	begin
		#1;
		if (memAck)
		begin
			if (!memReqValid)
			begin
				if (releaseLeft > 0)
					releaseLeft--;
				else
					memAck = 1'b0;	// req gone, release
			end
		end
		else if (memReqValid)
		begin
			if (!pending)
			begin
				pending = 1'b1;
				delayLeft = $urandom % 4;	// extra wait cycles
			end
			else if (delayLeft > 0)
				delayLeft--;
			else
				serveRequest();
		end
	end

	always @(posedge Clk)
	begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("%0t ns: timeout after %0d cycles, core never halted", $time, cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	reqRiseAck: assert property (@(posedge Clk) disable iff (!rstN)
		$rose(memReqValid) |-> !memAck)
	else
	begin
		errorCount++;
		$display("%0t ns: request raised while ack was still high", $time);
	end

	reqHold: assert property (@(posedge Clk) disable iff (!rstN)
		(memReqValid && !memAck) |=> (memReqValid && $stable(memReq)))
	else
	begin
		errorCount++;
		$display("%0t ns: request dropped or changed before ack", $time);
	end

	reqDrop: assert property (@(posedge Clk) disable iff (!rstN)
		(memReqValid && memAck) |=> !memReqValid)
	else
	begin
		errorCount++;
		$display("%0t ns: request still high the cycle after ack", $time);
	end

	noOverlap: assert property (@(posedge Clk) disable iff (!rstN)
		(memAck && !memReqValid) |=> !memReqValid)
	else
	begin
		errorCount++;
		$display("%0t ns: new request opened before ack of the last one dropped", $time);
	end

	haltQuiet: assert property (@(posedge Clk) disable iff (!rstN)
		halted |=> (halted && !memReqValid))
	else
	begin
		errorCount++;
		$display("%0t ns: memory request or halt release after break", $time);
	end

	initial
	begin
		void'($urandom(Seed));
		loadProgram();
		loadExpected();
		repeat (3) @(posedge Clk);
		#1;
		rstN = 1'b1;
		checkValue("memReqValid", {31'b0, memReqValid}, 32'h0);
		checkValue("halted", {31'b0, halted}, 32'h0);
		wait (halted === 1'b1);
		repeat (DrainCycles) @(posedge Clk);
		checkValue("halted", {31'b0, halted}, 32'h1);
		checkValue("storeCount", storeIdx, NumStores);	// table fully consumed
		checkValue("fetchCount", fetchCount, ExecutedInstr);
		$display("errors %0d, stores %0d of %0d, fetches %0d, cycles %0d",
			errorCount, storeIdx, NumStores, fetchCount, cycleCount);
		if (errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: sources.f
verilog/mipsPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/memPort.sv
verilog/datapath.sv
verilog/controlFsm.sv
verilog/mipsCore.sv
dv/mipsCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mipsCoreTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
